// ==== compile.f ====
+incdir+include
design/bus_pkg.sv
design/bus_access.sv
design/bus_decoder.sv
design/bus_ram.sv
design/bus_io.sv
design/bus_system.sv
tests/bus_system_tb.sv

// ==== design/bus_access.sv ====
`timescale 1ns/1ps

module bus_access #(
	parameter bit REGISTERED = 1'b1
)(
	input i_clock,
	input i_reset,

	// Port A, instruction fetch (read only)
	input bus_pkg::bus_req_t i_pa,
	output bus_pkg::bus_rsp_t o_pa,
	output logic o_pa_busy,

	// Port B, data load and store
	input bus_pkg::bus_req_t i_pb,
	output bus_pkg::bus_rsp_t o_pb,
	output logic o_pb_busy,

	// Port C, secondary master
	input bus_pkg::bus_req_t i_pc,
	output bus_pkg::bus_rsp_t o_pc,
	output logic o_pc_busy,

	// Shared bus
	output bus_pkg::bus_req_t o_bus,
	input bus_pkg::bus_rsp_t i_bus
);

	bus_pkg::grant_t grant;
	bus_pkg::grant_t pick;
	bus_pkg::bus_req_t pa_read;

	// Command of the port named by g or zero when idle
	function automatic bus_pkg::bus_req_t port_cmd(
		input bus_pkg::grant_t g,
		input bus_pkg::bus_req_t a,
		input bus_pkg::bus_req_t b,
		input bus_pkg::bus_req_t c
	);
		case (g)
			bus_pkg::GRANT_A: port_cmd = a;
			bus_pkg::GRANT_B: port_cmd = b;
			bus_pkg::GRANT_C: port_cmd = c;
			default: port_cmd = '0;
		endcase
	endfunction

	always_comb begin
		pa_read = i_pa;
		pa_read.rw = 1'b0;		// Fetch port never writes
		pa_read.wdata = '0;
	end

	// Fixed priority B, A, C
	always_comb begin
		if (i_pb.request)
			pick = bus_pkg::GRANT_B;
		else if (i_pa.request)
			pick = bus_pkg::GRANT_A;
		else if (i_pc.request)
			pick = bus_pkg::GRANT_C;
		else
			pick = bus_pkg::GRANT_IDLE;
	end

	// Choose only while idle and release on ready
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			grant <= bus_pkg::GRANT_IDLE;
		end
		else if (grant == bus_pkg::GRANT_IDLE) begin
			grant <= pick;
		end
		else if (i_bus.ready) begin
			grant <= bus_pkg::GRANT_IDLE;
		end
	end

	generate if (REGISTERED) begin : g_registered

		bus_pkg::bus_req_t bus_q;

		// Command captured at the grant edge and held until ready
		always_ff @(posedge i_clock) begin
			if (i_reset) begin
				bus_q.request <= 1'b0;
			end
			else if (grant == bus_pkg::GRANT_IDLE) begin
				bus_q <= port_cmd(pick, pa_read, i_pb, i_pc);
			end
			else if (i_bus.ready) begin
				bus_q.request <= 1'b0;
			end
		end

		assign o_bus = bus_q;

	end
	else begin : g_combinational

		// Bus follows the granted port directly
		assign o_bus = port_cmd(grant, pa_read, i_pb, i_pc);

	end endgenerate

	assign o_pa_busy = (grant == bus_pkg::GRANT_A);
	assign o_pb_busy = (grant == bus_pkg::GRANT_B);
	assign o_pc_busy = (grant == bus_pkg::GRANT_C);

	// Ready goes only to the granted port and read data to all
	always_comb begin
		o_pa.ready = o_pa_busy && i_pa.request && i_bus.ready;
		o_pa.rdata = i_bus.rdata;
		o_pb.ready = o_pb_busy && i_pb.request && i_bus.ready;
		o_pb.rdata = i_bus.rdata;
		o_pc.ready = o_pc_busy && i_pc.request && i_bus.ready;
		o_pc.rdata = i_bus.rdata;
	end

endmodule

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
	// From the arbiter
	input bus_pkg::bus_req_t i_bus,
	output bus_pkg::bus_rsp_t o_bus,

	// RAM target
	output bus_pkg::bus_req_t o_ram,
	input bus_pkg::bus_rsp_t i_ram,

	// I/O target
	output bus_pkg::bus_req_t o_io,
	input bus_pkg::bus_rsp_t i_io
);

	logic io_sel;

	assign io_sel = i_bus.address[bus_pkg::IO_SELECT_BIT];

	// Both targets see the command but only one sees request
	always_comb begin
		o_ram = i_bus;
		o_ram.request = i_bus.request && !io_sel;

		o_io = i_bus;
		o_io.request = i_bus.request && io_sel;
	end

	always_comb begin
		if (io_sel) begin
			o_bus = i_io;
		end
		else begin
			o_bus = i_ram;
		end
	end

endmodule

// ==== design/bus_io.sv ====
`timescale 1ns/1ps

module bus_io (
	input i_clock,
	input i_reset,

	input bus_pkg::bus_req_t i_bus,
	output bus_pkg::bus_rsp_t o_bus
);

	logic [31:0] regs [4];
	logic [1:0] wait_count;
	logic [1:0] index;
	logic ready;

	assign index = i_bus.address[3:2];
	assign ready = i_bus.request && (wait_count == 2'd2);	// One wait state

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= 2'd0;
		end
		else if (!i_bus.request || ready) begin
			wait_count <= 2'd0;
		end
		else begin
			wait_count <= wait_count + 2'd1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end
		else if (ready && i_bus.rw) begin
			regs[index] <= i_bus.wdata;
		end
	end

	always_comb begin
		o_bus.ready = ready;
		o_bus.rdata = regs[index];
	end

endmodule

// ==== design/bus_pkg.sv ====
package bus_pkg;

	`include "bus_map.svh"

	localparam int unsigned IO_SELECT_BIT = `BUS_IO_SELECT_BIT;

	// One bus command, as issued by a port or by the arbiter
	typedef struct packed {
		logic rw;				// 1 = write
		logic request;
		logic [31:0] address;	// Byte address, bits 1:0 ignored
		logic [31:0] wdata;
	} bus_req_t;

	// Target answer
	typedef struct packed {
		logic ready;			// One-cycle pulse
		logic [31:0] rdata;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		GRANT_IDLE,
		GRANT_A,
		GRANT_B,
		GRANT_C
	} grant_t;

endpackage

// ==== design/bus_ram.sv ====
`timescale 1ns/1ps

module bus_ram #(
	parameter int unsigned RAM_WORDS = 256,
	parameter int unsigned RAM_WAIT = 2
)(
	input i_clock,
	input i_reset,

	input bus_pkg::bus_req_t i_bus,
	output bus_pkg::bus_rsp_t o_bus
);

	localparam int unsigned INDEX_W = $clog2(RAM_WORDS);
	localparam int unsigned LAST = RAM_WAIT + 1;
	localparam int unsigned COUNT_W = $clog2(LAST + 1);

	logic [31:0] mem [RAM_WORDS];
	logic [COUNT_W-1:0] wait_count;
	logic [INDEX_W-1:0] index;
	logic ready;

	assign index = i_bus.address[INDEX_W+1:2];	// Word index wrapping at RAM_WORDS
	assign ready = i_bus.request && (wait_count == COUNT_W'(LAST));

	// Counts cycles with request high
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
		end
		else if (!i_bus.request || ready) begin
			wait_count <= '0;
		end
		else begin
			wait_count <= wait_count + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (ready && i_bus.rw) begin
			mem[index] <= i_bus.wdata;
		end
	end

	always_comb begin
		o_bus.ready = ready;
		o_bus.rdata = mem[index];
	end

endmodule

// ==== design/bus_system.sv ====
`timescale 1ns/1ps

module bus_system #(
	parameter bit REGISTERED = 1'b1,
	parameter int unsigned RAM_WORDS = 256,
	parameter int unsigned RAM_WAIT = 2
)(
	input i_clock,
	input i_reset,

	input bus_pkg::bus_req_t i_pa,
	output bus_pkg::bus_rsp_t o_pa,
	output logic o_pa_busy,

	input bus_pkg::bus_req_t i_pb,
	output bus_pkg::bus_rsp_t o_pb,
	output logic o_pb_busy,

	input bus_pkg::bus_req_t i_pc,
	output bus_pkg::bus_rsp_t o_pc,
	output logic o_pc_busy
);

	bus_pkg::bus_req_t bus_cmd;
	bus_pkg::bus_rsp_t bus_rsp;
	bus_pkg::bus_req_t ram_cmd;
	bus_pkg::bus_rsp_t ram_rsp;
	bus_pkg::bus_req_t io_cmd;
	bus_pkg::bus_rsp_t io_rsp;

	bus_access #(
		.REGISTERED(REGISTERED)
	) u_access (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pa(i_pa),
		.o_pa(o_pa),
		.o_pa_busy(o_pa_busy),
		.i_pb(i_pb),
		.o_pb(o_pb),
		.o_pb_busy(o_pb_busy),
		.i_pc(i_pc),
		.o_pc(o_pc),
		.o_pc_busy(o_pc_busy),
		.o_bus(bus_cmd),
		.i_bus(bus_rsp)
	);

	bus_decoder u_decoder (
		.i_bus(bus_cmd),
		.o_bus(bus_rsp),
		.o_ram(ram_cmd),
		.i_ram(ram_rsp),
		.o_io(io_cmd),
		.i_io(io_rsp)
	);

	bus_ram #(
		.RAM_WORDS(RAM_WORDS),
		.RAM_WAIT(RAM_WAIT)
	) u_ram (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(ram_cmd),
		.o_bus(ram_rsp)
	);

	bus_io u_io (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(io_cmd),
		.o_bus(io_rsp)
	);

endmodule

// ==== include/bus_map.svh ====
`ifndef BUS_MAP_SVH
`define BUS_MAP_SVH

// RAM occupies the lower half of the address space
`define BUS_RAM_BASE 32'h0000_0000

// Any address with bit 31 set lands in the I/O block
`define BUS_IO_BASE 32'h8000_0000
`define BUS_IO_SELECT_BIT 31

// Four word registers, selected by address bits 3:2
`define BUS_IO_REGS 4

`endif

// ==== tests/bus_system_tb.sv ====
`timescale 1ns/1ps

`include "bus_map.svh"

module bus_system_tb;

	parameter bit REGISTERED = 1'b1;
	parameter int unsigned RAM_WORDS = 256;
	parameter int unsigned RAM_WAIT = 2;

	localparam int TIMEOUT_CYCLES = 10000;
	localparam int RANDOM_OPS = 200;

	localparam int PORT_A = 0;
	localparam int PORT_B = 1;
	localparam int PORT_C = 2;

	logic clock;
	logic reset;

	bus_pkg::bus_req_t pa;
	bus_pkg::bus_req_t pb;
	bus_pkg::bus_req_t pc;
	bus_pkg::bus_rsp_t pa_rsp;
	bus_pkg::bus_rsp_t pb_rsp;
	bus_pkg::bus_rsp_t pc_rsp;
	logic pa_busy;
	logic pb_busy;
	logic pc_busy;

	// Reference model of both targets
	logic [31:0] ram_model [RAM_WORDS];
	logic [31:0] io_model [`BUS_IO_REGS];

	int mismatch_count;
	int protocol_count;
	int timeout_count;
	int read_count;
	int monitor_edges;
	bit record_order;
	int ready_order [$];

	bus_system #(
		.REGISTERED(REGISTERED),
		.RAM_WORDS(RAM_WORDS),
		.RAM_WAIT(RAM_WAIT)
	) UUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_pa(pa),
		.o_pa(pa_rsp),
		.o_pa_busy(pa_busy),
		.i_pb(pb),
		.o_pb(pb_rsp),
		.o_pb_busy(pb_busy),
		.i_pc(pc),
		.o_pc(pc_rsp),
		.o_pc_busy(pc_busy)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic string port_name(input int port);
		case (port)
			PORT_A: port_name = "o_pa";
			PORT_B: port_name = "o_pb";
			default: port_name = "o_pc";
		endcase
	endfunction

	function automatic bus_pkg::bus_req_t port_command(input int port);
		case (port)
			PORT_A: port_command = pa;
			PORT_B: port_command = pb;
			default: port_command = pc;
		endcase
	endfunction

	function automatic bus_pkg::bus_rsp_t port_response(input int port);
		case (port)
			PORT_A: port_response = pa_rsp;
			PORT_B: port_response = pb_rsp;
			default: port_response = pc_rsp;
		endcase
	endfunction

	function automatic logic port_busy(input int port);
		case (port)
			PORT_A: port_busy = pa_busy;
			PORT_B: port_busy = pb_busy;
			default: port_busy = pc_busy;
		endcase
	endfunction

	// Preload word mixing every bit of the index
	function automatic logic [31:0] fill_pattern(input int unsigned index);
		fill_pattern = (index * 32'h9e37_79b9) ^ {index[15:0], 16'h0} ^ 32'h5a5a_0f0f;
	endfunction

	// Word the model holds at a byte address
	function automatic logic [31:0] expected_read(input logic [31:0] address);
		if (address[`BUS_IO_SELECT_BIT])
			expected_read = io_model[address[3:2]];
		else
			expected_read = ram_model[(address >> 2) % RAM_WORDS];
	endfunction

	function automatic void model_write(input logic [31:0] address, input logic [31:0] data);
		if (address[`BUS_IO_SELECT_BIT])
			io_model[address[3:2]] = data;
		else
			ram_model[(address >> 2) % RAM_WORDS] = data;
	endfunction

	task automatic finish_run;
		$display("Errors: %0d mismatches, %0d protocol, %0d timeouts, %0d reads checked",
			mismatch_count, protocol_count, timeout_count, read_count);
		if (mismatch_count == 0 && protocol_count == 0 && timeout_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			mismatch_count++;
			$display("mismatch %s: 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic drive_port(input int port, input bus_pkg::bus_req_t cmd);
		case (port)
			PORT_A: pa = cmd;
			PORT_B: pb = cmd;
			default: pc = cmd;
		endcase
	endtask

	// One access with the request held until ready
	task automatic run_access(
		input int port,
		input logic rw,
		input logic [31:0] address,
		input logic [31:0] data,
		output logic [31:0] rdata
	);
		bus_pkg::bus_req_t cmd;
		bus_pkg::bus_rsp_t rsp;
		int waited;
		cmd.rw = (port == PORT_A) ? 1'b0 : rw;	// Fetch port only reads
		cmd.request = 1'b1;
		cmd.address = address;
		cmd.wdata = (port == PORT_A) ? 32'h0 : data;
		waited = 0;
		@(negedge clock);
		drive_port(port, cmd);
		forever begin
			@(posedge clock);
			rsp = port_response(port);
			if (rsp.ready)
				break;
			waited++;
			if (waited >= TIMEOUT_CYCLES) begin
				timeout_count++;
				$display("Error: %s got no ready within %0d cycles", port_name(port),
					TIMEOUT_CYCLES);
				finish_run();
			end
		end
		rdata = rsp.rdata;
		@(negedge clock);
		drive_port(port, '0);	// Request low for at least one cycle
	endtask

	task automatic random_traffic(input int port);
		logic [31:0] address;
		logic [31:0] data;
		logic [31:0] rdata;
		logic rw;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			address = $urandom;
			address[`BUS_IO_SELECT_BIT] = ($urandom % 3 == 0);	// About a third go to I/O
			data = $urandom;
			rw = (port == PORT_A) ? 1'b0 : ($urandom % 2 == 1);
			repeat ($urandom % 4) @(negedge clock);
			run_access(port, rw, address, data, rdata);
		end
	endtask

	// Compares every completed access
	always @(posedge clock) begin : monitor
		bus_pkg::bus_req_t cmd;
		bus_pkg::bus_rsp_t rsp;
		logic [31:0] expected;
		int granted;
		if (monitor_edges > 0) begin
			granted = int'(pa_busy) + int'(pb_busy) + int'(pc_busy);
			if (reset && (granted != 0 || pa_rsp.ready || pb_rsp.ready || pc_rsp.ready)) begin
				protocol_count++;
				$display("Error: ready or busy high during reset at %0t", $time);
			end
			if (granted > 1) begin
				protocol_count++;
				$display("Error: more than one port granted at %0t", $time);
			end
			for (int p = 0; p < 3; p++) begin
				cmd = port_command(p);
				rsp = port_response(p);
				if (rsp.ready && !port_busy(p)) begin
					protocol_count++;
					$display("Error: ready on %s while its busy is low at %0t", port_name(p),
						$time);
				end
				if (rsp.ready && !reset) begin
					if (record_order)
						ready_order.push_back(p);
					if (cmd.rw) begin
						model_write(cmd.address, cmd.wdata);
					end
					else begin
						expected = expected_read(cmd.address);
						read_count++;
						if (rsp.rdata !== expected) begin
							mismatch_count++;
							$display("mismatch %s.rdata: 0x%h expected 0x%h at address 0x%h",
								port_name(p), rsp.rdata, expected, cmd.address);
						end
					end
				end
			end
		end
		monitor_edges++;
	end

	initial begin
		logic [31:0] rdata;
		logic [31:0] rd_a;
		logic [31:0] rd_c;
		void'($urandom(32'h1f0a0c99));
		mismatch_count = 0;
		protocol_count = 0;
		timeout_count = 0;
		read_count = 0;
		monitor_edges = 0;
		record_order = 1'b0;
		for (int i = 0; i < `BUS_IO_REGS; i++)
			io_model[i] = 32'h0;
		reset = 1'b1;
		pa = '0;
		pb = '0;
		pc = '0;
		repeat (8) @(negedge clock);
		reset = 1'b0;

		@(posedge clock);
		if (pa_busy || pb_busy || pc_busy || pa_rsp.ready || pb_rsp.ready || pc_rsp.ready) begin
			protocol_count++;
			$display("Error: ready or busy high right after reset");
		end

		// I/O registers come out of reset as zero
		for (int i = 0; i < `BUS_IO_REGS; i++) begin
			run_access(PORT_C, 1'b0, `BUS_IO_BASE | (32'(i) << 2), 32'h0, rdata);
			check_word("o_pc.rdata", rdata, 32'h0);
		end

		// RAM is not reset so every word gets a known value
		for (int i = 0; i < RAM_WORDS; i++)
			run_access(PORT_B, 1'b1, `BUS_RAM_BASE + (32'(i) << 2), fill_pattern(i), rdata);

		// Write then read on each port
		run_access(PORT_B, 1'b1, 32'h0000_0040, 32'hcafe_0001, rdata);
		run_access(PORT_B, 1'b0, 32'h0000_0040, 32'h0, rdata);
		check_word("o_pb.rdata", rdata, 32'hcafe_0001);
		run_access(PORT_C, 1'b1, 32'h0000_0080, 32'h0bad_f00d, rdata);
		run_access(PORT_C, 1'b0, 32'h0000_0080, 32'h0, rdata);
		check_word("o_pc.rdata", rdata, 32'h0bad_f00d);
		run_access(PORT_C, 1'b1, 32'h0000_0040, 32'h1234_5678, rdata);
		run_access(PORT_A, 1'b0, 32'h0000_0040, 32'h0, rdata);
		check_word("o_pa.rdata", rdata, 32'h1234_5678);

		// I/O writes leave RAM words with the same low bits alone
		for (int i = 0; i < `BUS_IO_REGS; i++)
			run_access(PORT_B, 1'b1, `BUS_IO_BASE | (32'(i) << 2), 32'h10 + 32'(i), rdata);
		for (int i = 0; i < `BUS_IO_REGS; i++) begin
			run_access(PORT_A, 1'b0, 32'(i) << 2, 32'h0, rdata);
			check_word("o_pa.rdata", rdata, fill_pattern(i));
			run_access(PORT_C, 1'b0, `BUS_IO_BASE | (32'(i) << 2), 32'h0, rdata);
			check_word("o_pc.rdata", rdata, 32'h10 + 32'(i));
		end
		run_access(PORT_A, 1'b0, (RAM_WORDS * 4) + 8, 32'h0, rdata);	// Index wraps
		check_word("o_pa.rdata", rdata, fill_pattern(2));

		// All three on the same edge while idle
		ready_order.delete();
		record_order = 1'b1;
		fork
			run_access(PORT_A, 1'b0, 32'h0000_0010, 32'h0, rd_a);
			run_access(PORT_B, 1'b1, 32'h0000_0014, 32'h7777_aaaa, rdata);
			run_access(PORT_C, 1'b0, `BUS_IO_BASE | 32'h4, 32'h0, rd_c);
		join
		record_order = 1'b0;
		if (ready_order.size() != 3 || ready_order[0] != PORT_B || ready_order[1] != PORT_A ||
			ready_order[2] != PORT_C) begin
			protocol_count++;
			$display("Error: readies did not arrive in the order B, A, C");
		end
		check_word("o_pa.rdata", rd_a, fill_pattern(4));
		check_word("o_pc.rdata", rd_c, 32'h11);

		fork
			random_traffic(PORT_A);
			random_traffic(PORT_B);
			random_traffic(PORT_C);
		join

		repeat (4) @(negedge clock);
		finish_run();
	end

endmodule
